//--- led_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// led strip package
// pixel and word types, SK9822 frame constants
// and the APB register map of the LED strip.
// ~~~~~~~~~~~~~~~~~~~~

package led_pkg;

    // one pixel, red in the top byte.
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    typedef logic [31:0] led_word_t;
    typedef logic [4:0]  bright_t;

    // frame delimiters.
    localparam led_word_t START_WORD = 32'h0000_0000;
    localparam led_word_t END_WORD   = 32'hffff_ffff;
    localparam logic [2:0] LED_HDR   = 3'b111;

    // byte offsets on the APB side.
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_BRIGHT = 8'h08;
    localparam logic [7:0] PIX_BASE   = 8'h40;

endpackage

//--- apb_led_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// apb led registers
// APB slave with control, status, brightness and
// a pixel window mapped onto the frame RAM.
// pixel reads take one wait state.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module apb_led_regs #(
    parameter int NUM_LEDS = 12,
    localparam int AW = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1
) (
    input  logic              ck,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              we,
    output logic [AW-1:0]     waddr,
    output led_pkg::pixel_t   wdata,
    output logic              ra_en,
    output logic [AW-1:0]     ra_addr,
    input  led_pkg::pixel_t   ra_data,
    output logic              start,
    output led_pkg::bright_t  bright,
    input  logic              busy
);
    import led_pkg::*;

    logic       access;
    logic       is_ctrl;
    logic       is_status;
    logic       is_bright;
    logic       is_pix;
    logic       pix_ok;
    logic       err;
    logic       pix_rd;
    logic       rd_pend;
    logic [7:0] offs;
    logic [5:0] pix_idx;

    assign access    = psel && penable;
    assign is_ctrl   = (paddr == REG_CTRL);
    assign is_status = (paddr == REG_STATUS);
    assign is_bright = (paddr == REG_BRIGHT);

    // pixel window, word aligned only.
    assign offs    = paddr - PIX_BASE;
    assign pix_idx = offs[7:2];
    assign is_pix  = (paddr >= PIX_BASE) && (paddr[1:0] == 2'b00);
    assign pix_ok  = is_pix && (pix_idx < NUM_LEDS);

    assign err = !(is_ctrl || is_status || is_bright || pix_ok) || (pwrite && is_status);

    assign pix_rd  = access && !pwrite && pix_ok;
    assign pready  = access && (!pix_rd || rd_pend);
    assign pslverr = pready && err;

    assign ra_en   = pix_rd && !rd_pend;
    assign ra_addr = pix_idx[AW-1:0];
    assign we      = access && pwrite && pix_ok;
    assign waddr   = pix_idx[AW-1:0];
    assign wdata   = pwdata[23:0];

    // dropped while a frame runs.
    assign start = access && pwrite && is_ctrl && pwdata[0] && !busy;

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            bright  <= 5'd31;
        end else begin
            rd_pend <= ra_en;
            if (access && pwrite && is_bright)
                bright <= pwdata[4:0];
        end
    end

    always_comb begin
        prdata = '0;
        if (is_status)
            prdata[0] = busy;
        else if (is_bright)
            prdata[4:0] = bright;
        else if (pix_ok)
            prdata[23:0] = ra_data;
    end

endmodule

//--- pixel_ram.sv
// ~~~~~~~~~~~~~~~~~~~~
// pixel ram
// frame buffer, one write port and two
// registered read ports.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pixel_ram #(
    parameter int NUM_LEDS = 12,
    localparam int AW = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1
) (
    input  logic              ck,
    input  logic              we,
    input  logic [AW-1:0]     waddr,
    input  led_pkg::pixel_t   wdata,
    input  logic              ra_en,
    input  logic [AW-1:0]     ra_addr,
    output led_pkg::pixel_t   ra_data,
    input  logic              rb_en,
    input  logic [AW-1:0]     rb_addr,
    output led_pkg::pixel_t   rb_data
);
    import led_pkg::*;

    pixel_t mem [NUM_LEDS];

    always_ff @(posedge ck) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read before write on a shared index.
    always_ff @(posedge ck) begin
        if (ra_en)
            ra_data <= mem[ra_addr];
    end

    always_ff @(posedge ck) begin
        if (rb_en)
            rb_data <= mem[rb_addr];
    end

endmodule

//--- frame_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~
// frame sequencer
// sends the start word, one word per LED and the
// end word, prefetching pixels from the RAM while
// the current word shifts out.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frame_sequencer #(
    parameter int NUM_LEDS = 12,
    localparam int AW = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1
) (
    input  logic               ck,
    input  logic               rst_n,
    input  logic               start,
    input  led_pkg::bright_t   bright,
    output logic               busy,
    output logic               rb_en,
    output logic [AW-1:0]      rb_addr,
    input  led_pkg::pixel_t    rb_data,
    output logic               load,
    output led_pkg::led_word_t word,
    input  logic               shifter_busy
);
    import led_pkg::*;

    localparam int CW = $clog2(NUM_LEDS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PIXELS,
        S_END,
        S_DRAIN
    } state_t;

    state_t        state;
    logic [CW-1:0] idx;
    logic          pend;
    logic          rd_out;
    logic          slot_free;
    logic          last_pix;
    bright_t       bright_q;

    // pend means a word waits for the shifter.
    assign load      = pend && !shifter_busy;
    assign slot_free = !pend || load;
    assign last_pix  = (idx == CW'(NUM_LEDS));

    assign rb_en   = (state == S_PIXELS) && !rd_out && slot_free && !last_pix;
    assign rb_addr = idx[AW-1:0];

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            busy   <= 1'b0;
            pend   <= 1'b0;
            rd_out <= 1'b0;
            idx    <= '0;
        end else begin
            if (load)
                pend <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        pend  <= 1'b1;
                        idx   <= '0;
                        state <= S_PIXELS;
                    end
                end
                S_PIXELS: begin
                    if (rd_out) begin
                        rd_out <= 1'b0;
                        pend   <= 1'b1;
                    end
                    if (rb_en) begin
                        rd_out <= 1'b1;
                        idx    <= idx + 1'b1;
                    end else if (!rd_out && slot_free && last_pix) begin
                        pend  <= 1'b1;
                        state <= S_END;
                    end
                end
                S_END: begin
                    if (load)
                        state <= S_DRAIN;
                end
                S_DRAIN: begin
                    // shifter busy is already up the cycle after load.
                    if (!shifter_busy) begin
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word and latched brightness.
    always_ff @(posedge ck) begin
        if (state == S_IDLE && start) begin
            bright_q <= bright;
            word     <= START_WORD;
        end else if (state == S_PIXELS && rd_out) begin
            word <= {LED_HDR, bright_q, rb_data.blue, rb_data.green, rb_data.red};
        end else if (state == S_PIXELS && !rd_out && slot_free && last_pix) begin
            word <= END_WORD;
        end
    end

endmodule

//--- sk9822_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~
// sk9822 shifter
// shifts a 32-bit word out MSB first, two ck
// cycles per bit, with led_ck as a register.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sk9822_shifter (
    input  logic               ck,
    input  logic               rst_n,
    input  logic               load,
    input  led_pkg::led_word_t word,
    output logic               shifter_busy,
    output logic               led_data,
    output logic               led_ck
);
    import led_pkg::*;

    led_word_t  shift;
    logic [4:0] cnt;
    logic       take;
    logic       next_bit;

    assign take     = load && !shifter_busy;
    assign next_bit = shifter_busy && led_ck && (cnt != 5'd31);

    // data only moves when led_ck falls, so it stays
    // put across each rising edge and while idle.
    always_ff @(posedge ck) begin
        if (!rst_n) begin
            shifter_busy <= 1'b0;
            led_ck       <= 1'b1;
            led_data     <= 1'b0;
            cnt          <= '0;
        end else if (take) begin
            shifter_busy <= 1'b1;
            led_ck       <= 1'b0;
            led_data     <= word[31];
            cnt          <= '0;
        end else if (shifter_busy) begin
            if (!led_ck) begin
                led_ck <= 1'b1;
            end else if (next_bit) begin
                led_ck   <= 1'b0;
                led_data <= shift[30];
                cnt      <= cnt + 1'b1;
            end else begin
                shifter_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge ck) begin
        if (take)
            shift <= word;
        else if (next_bit)
            shift <= {shift[30:0], 1'b0};
    end

endmodule

//--- led_strip_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// led strip top
// APB register port, pixel RAM, frame sequencer
// and SK9822 shifter for one LED chain.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module led_strip_top #(
    parameter int NUM_LEDS = 12
) (
    input  logic        ck,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        led_data,
    output logic        led_ck
);
    import led_pkg::*;

    localparam int AW = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;

    logic          we;
    logic [AW-1:0] waddr;
    pixel_t        wdata;
    logic          ra_en;
    logic [AW-1:0] ra_addr;
    pixel_t        ra_data;
    logic          rb_en;
    logic [AW-1:0] rb_addr;
    pixel_t        rb_data;
    logic          start;
    bright_t       bright;
    logic          busy;
    logic          load;
    led_word_t     word;
    logic          shifter_busy;

    apb_led_regs #(.NUM_LEDS(NUM_LEDS)) u_regs (
        .ck(ck), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .we(we), .waddr(waddr), .wdata(wdata),
        .ra_en(ra_en), .ra_addr(ra_addr), .ra_data(ra_data),
        .start(start), .bright(bright), .busy(busy)
    );

    pixel_ram #(.NUM_LEDS(NUM_LEDS)) u_ram (
        .ck(ck), .we(we), .waddr(waddr), .wdata(wdata),
        .ra_en(ra_en), .ra_addr(ra_addr), .ra_data(ra_data),
        .rb_en(rb_en), .rb_addr(rb_addr), .rb_data(rb_data)
    );

    frame_sequencer #(.NUM_LEDS(NUM_LEDS)) u_seq (
        .ck(ck), .rst_n(rst_n), .start(start), .bright(bright), .busy(busy),
        .rb_en(rb_en), .rb_addr(rb_addr), .rb_data(rb_data),
        .load(load), .word(word), .shifter_busy(shifter_busy)
    );

    sk9822_shifter u_shift (
        .ck(ck), .rst_n(rst_n), .load(load), .word(word),
        .shifter_busy(shifter_busy), .led_data(led_data), .led_ck(led_ck)
    );

endmodule

//--- tb_led_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// led strip assertions
// APB handshake rules and LED data hold
// around the rising LED clock.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_led_assert (
    input logic ck,
    input logic rst_n,
    input logic psel,
    input logic pready,
    input logic led_data,
    input logic led_ck
);

    a_psel_hold: assert property (@(posedge ck) disable iff (!rst_n)
        psel && !pready |=> psel)
        else $error("psel dropped before the transfer completed");

    a_ready_idle: assert property (@(posedge ck) disable iff (!rst_n)
        !psel |-> !pready)
        else $error("pready high without psel");

    // LED samples on the rising edge.
    a_data_hold: assert property (@(posedge ck) disable iff (!rst_n)
        led_ck |-> $stable(led_data))
        else $error("led_data moved while led_ck was high");

endmodule

bind led_strip_top tb_led_assert u_assert (
    .ck(ck), .rst_n(rst_n), .psel(psel), .pready(pready),
    .led_data(led_data), .led_ck(led_ck)
);

//--- tb_led_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// led strip checker
// shadows pixels and brightness from APB writes,
// rebuilds LED words from the serial lines and
// compares reads, wait states and frames.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_led_checker #(
    parameter int NUM_LEDS = 12
) (
    input  logic        ck,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic        led_data,
    input  logic        led_ck,
    input  logic [31:0] exp_data,
    input  logic        exp_err,
    input  logic        chk_data,
    input  int          frames_started,
    output int          apb_errs,
    output int          frame_errs
);
    import led_pkg::*;

    pixel_t    shadow [NUM_LEDS];
    bright_t   bright_m;
    bright_t   bright_snap;
    led_word_t sreg;
    led_word_t exp_word;
    int        nbits;
    int        nwords;
    int        frames_seen;
    int        waits;
    int        exp_wait;
    int        idx;
    logic      is_pix;
    logic      ck_q;
    logic      rst_q;

    always @(posedge ck) begin
        if (!rst_n) begin
            apb_errs    = 0;
            frame_errs  = 0;
            waits       = 0;
            nbits       = 0;
            nwords      = 0;
            frames_seen = 0;
            bright_m    = 5'd31;
        end else begin
            if (!rst_q && (led_ck !== 1'b1 || led_data !== 1'b0)) begin
                frame_errs++;
                $display("[FAIL] %0d ns: led lines %b/%b after reset", $time, led_ck, led_data);
            end
            idx      = (paddr - PIX_BASE) >> 2;
            is_pix   = (paddr >= PIX_BASE) && (idx < NUM_LEDS);
            exp_wait = (!pwrite && is_pix && !exp_err) ? 1 : 0;
            if (psel && penable && !pready) begin
                waits++;
            end else if (psel && penable) begin
                if (pslverr !== exp_err || waits != exp_wait) begin
                    apb_errs++;
                    $display("[FAIL] %0d ns: addr %h pslverr %b after %0d waits",
                             $time, paddr, pslverr, waits);
                end else if (chk_data && prdata !== exp_data) begin
                    apb_errs++;
                    $display("[FAIL] %0d ns: addr %h read %h, expected %h",
                             $time, paddr, prdata, exp_data);
                end
                waits = 0;
                if (pwrite && !exp_err && is_pix)
                    shadow[idx] = pwdata[23:0];
                if (pwrite && !exp_err && paddr == REG_BRIGHT)
                    bright_m = pwdata[4:0];
                // idle status must follow whole frames only.
                if (!pwrite && paddr == REG_STATUS && prdata[0] === 1'b0 &&
                    (frames_seen != frames_started || nbits != 0 || nwords != 0)) begin
                    frame_errs++;
                    $display("[FAIL] %0d ns: idle after %0d frames and %0d words, %0d started",
                             $time, frames_seen, nwords, frames_started);
                end
            end
            if (ck_q === 1'b0 && led_ck === 1'b1) begin
                if (nbits == 0 && nwords == 0)
                    bright_snap = bright_m;
                sreg = {sreg[30:0], led_data};
                nbits++;
                if (nbits == 32) begin
                    nbits = 0;
                    if (nwords == 0)
                        exp_word = START_WORD;
                    else if (nwords == NUM_LEDS + 1)
                        exp_word = END_WORD;
                    else
                        exp_word = {LED_HDR, bright_snap, shadow[nwords-1].blue,
                                    shadow[nwords-1].green, shadow[nwords-1].red};
                    if (sreg !== exp_word) begin
                        frame_errs++;
                        $display("[FAIL] %0d ns: word %0d is %h, expected %h",
                                 $time, nwords, sreg, exp_word);
                    end
                    nwords++;
                    if (nwords == NUM_LEDS + 2) begin
                        nwords = 0;
                        frames_seen++;
                    end
                end
            end
        end
        ck_q  = led_ck;
        rst_q = rst_n;
    end

endmodule

//--- tb_led_strip.sv
// ~~~~~~~~~~~~~~~~~~~~
// led strip testbench
// clock, reset, APB driver fed from a case
// file, random idle gaps and a run watchdog.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_led_strip;
    import led_pkg::*;

    localparam int NUM_LEDS = 12;

    logic        ck = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        led_data;
    logic        led_ck;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        chk_data;
    int          frames_started;
    int          apb_errs;
    int          frame_errs;
    int          setup_errs;
    logic [7:0]  lfsr;
    logic        loaded;
    logic [31:0] rd;
    logic [7:0]  op_q[$];
    logic [7:0]  addr_q[$];
    logic [31:0] data_q[$];
    logic        err_q[$];

    led_strip_top #(.NUM_LEDS(NUM_LEDS)) uut (
        .ck(ck), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .led_data(led_data), .led_ck(led_ck)
    );

    tb_led_checker #(.NUM_LEDS(NUM_LEDS)) u_chk (
        .ck(ck), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .led_data(led_data), .led_ck(led_ck),
        .exp_data(exp_data), .exp_err(exp_err), .chk_data(chk_data),
        .frames_started(frames_started),
        .apb_errs(apb_errs), .frame_errs(frame_errs)
    );

    always #50 ck = ~ck;

    // 8-bit fibonacci, taps 8 6 5 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic idle_gap();
        int n;
        lfsr = lfsr_step(lfsr);
        n = lfsr[0];
        lfsr = lfsr_step(lfsr);
        n = n * 2 + lfsr[0];
        repeat (n) @(posedge ck);
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [7:0]  a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("led_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open led_cases.txt");
            setup_errs++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h", op, a, d, e);
                    if (n == 4) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        err_q.push_back(e[0]);
                    end
                end
            end
            $fclose(fd);
            if (op_q.size() == 0) begin
                $display("no cases found in led_cases.txt");
                setup_errs++;
            end
        end
    endtask

    // one APB transfer, setup then access until pready.
    task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] d,
                            input logic [31:0] exp, input logic err, input logic chk,
                            output logic [31:0] data);
        @(posedge ck);
        #10;
        psel     = 1'b1;
        pwrite   = wr;
        paddr    = a;
        pwdata   = d;
        exp_data = exp;
        exp_err  = err;
        chk_data = chk;
        @(posedge ck);
        #10;
        penable = 1'b1;
        @(posedge ck);
        while (!pready)
            @(posedge ck);
        data = prdata;
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        idle_gap();
    endtask

    initial begin
        rst_n          = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        exp_data       = '0;
        exp_err        = 1'b0;
        chk_data       = 1'b0;
        frames_started = 0;
        setup_errs     = 0;
        lfsr           = 8'd37;
        loaded         = 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (16) @(posedge ck);
        #10;
        rst_n = 1'b1;
        foreach (op_q[i]) begin
            case (op_q[i])
                "w": apb_xfer(1'b1, addr_q[i], data_q[i], '0, err_q[i], 1'b0, rd);
                "r": apb_xfer(1'b0, addr_q[i], '0, data_q[i], err_q[i], 1'b1, rd);
                "s": begin
                    frames_started++;
                    apb_xfer(1'b1, REG_CTRL, 32'd1, '0, 1'b0, 1'b0, rd);
                end
                "p": begin
                    do
                        apb_xfer(1'b0, REG_STATUS, '0, '0, 1'b0, 1'b0, rd);
                    while (rd[0]);
                end
                default: begin
                    $display("unknown operation in case line %0d", i);
                    setup_errs++;
                end
            endcase
        end
        repeat (4) @(posedge ck);
        $display("errors: apb %0d, frame %0d, setup %0d", apb_errs, frame_errs, setup_errs);
        if (apb_errs + frame_errs + setup_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // a full frame per case is far more than any case needs.
    initial begin
        wait (loaded);
        repeat ((op_q.size() + 1) * (NUM_LEDS + 2) * 64 * 2) @(posedge ck);
        $display("run timed out before all cases finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- led_cases.txt
# op addr data err (hex)
# w write, r read and compare, s start frame, p poll STATUS until idle
r 04 00000000 0
r 08 0000001f 0
w 40 00ff0000 0
w 44 0000ff00 0
w 48 000000ff 0
w 4c 00123456 0
w 50 00abcdef 0
w 54 00000001 0
w 58 00800000 0
w 5c 00fedcba 0
w 60 00a5a55a 0
w 64 00010203 0
w 68 007f7f7f 0
w 6c 00c0ffee 0
r 40 00ff0000 0
r 6c 00c0ffee 0
w 08 00000010 0
r 08 00000010 0
s 00 00000001 0
w 00 00000001 0
p 04 00000000 0
w 30 12345678 1
w 70 00abcdef 1
r 7c 00000000 1
w 04 00000001 1
r 6c 00c0ffee 0
w 08 00000003 0
s 00 00000001 0
p 04 00000000 0

//--- list.f
led_pkg.sv
apb_led_regs.sv
pixel_ram.sv
frame_sequencer.sv
sk9822_shifter.sv
led_strip_top.sv
tb_led_assert.sv
tb_led_checker.sv
tb_led_strip.sv

//--- run.sh
#!/bin/sh
# build and run the LED strip testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_led_strip -f list.f -o sim_led
./obj_dir/sim_led > sim.log 2>&1 || echo "** FAIL **" >> sim.log
cat sim.log

if grep -qF "** FAIL **" sim.log; then
    exit 1
fi
exit 0
